/* core_isa_pkg.sv */
package core_isa_pkg;

    // architectural widths
    localparam int XLEN      = 32;
    localparam int INST_W    = 32;
    localparam int RF_ADDR_W = 5;
    localparam int RF_DEPTH  = 32;
    localparam int SHAMT_W   = 5;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [6:0]           opcode_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;

    // major opcodes, only the integer alu groups
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;

    // funct3 field
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct7 bit that turns add into sub and srl into sra
    localparam int F7_ALT_BIT = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

endpackage

/* core_pipe_pkg.sv */
package core_pipe_pkg;

    // decode, execute, memory, writeback
    localparam int PIPE_STAGES = 4;
    localparam int FLUSH_CNT_W = $clog2(PIPE_STAGES);
    localparam int CNT_W       = 32;

    typedef logic [PIPE_STAGES-1:0] stage_vec_t;
    typedef logic [FLUSH_CNT_W-1:0] flush_cnt_t;
    typedef logic [CNT_W-1:0]       cnt_t;

    // operand source, register/immediate or a bypassed result
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WBK
    } fwd_sel_t;

    typedef enum logic [1:0] {
        ST_FLUSH,
        ST_RUN
    } ctrl_state_t;

endpackage

/* pipe_ctrl.sv */
`timescale 1ns/10ps

module pipe_ctrl (
    input  logic clk,
    input  logic rst,
    output logic run_o
);

    core_pipe_pkg::ctrl_state_t state_q;
    core_pipe_pkg::flush_cnt_t  flush_cnt_q;
    // one bit per stage, cleared front to back
    core_pipe_pkg::stage_vec_t  stage_flush_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= core_pipe_pkg::ST_FLUSH;
            flush_cnt_q   <= core_pipe_pkg::flush_cnt_t'(core_pipe_pkg::PIPE_STAGES - 1);
            stage_flush_q <= '1;
        end else begin
            case (state_q)
                core_pipe_pkg::ST_FLUSH: begin
                    stage_flush_q <= {stage_flush_q[core_pipe_pkg::PIPE_STAGES-2:0], 1'b0};
                    if (flush_cnt_q == '0) begin
                        state_q <= core_pipe_pkg::ST_RUN;
                    end else begin
                        flush_cnt_q <= flush_cnt_q - 1'b1;
                    end
                end
                core_pipe_pkg::ST_RUN: begin
                    // no way back out short of reset
                    state_q <= core_pipe_pkg::ST_RUN;
                end
                default: begin
                    state_q <= core_pipe_pkg::ST_FLUSH;
                end
            endcase
        end
    end

    // accept only once the last stage is clean
    assign run_o = (state_q == core_pipe_pkg::ST_RUN) &&
                   !stage_flush_q[core_pipe_pkg::PIPE_STAGES-1];

endmodule

/* perf_counter.sv */
`timescale 1ns/10ps

module perf_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                run_i,
    input  logic                accept_i,
    input  logic                retire_i,
    output core_pipe_pkg::cnt_t cycle_o,
    output core_pipe_pkg::cnt_t instret_o,
    output core_pipe_pkg::cnt_t bubble_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_o   <= '0;
            instret_o <= '0;
            bubble_o  <= '0;
        end else if (run_i) begin
            cycle_o <= cycle_o + core_pipe_pkg::cnt_t'(1);
            if (retire_i) begin
                instret_o <= instret_o + core_pipe_pkg::cnt_t'(1);
            end
            // idle decode slot
            if (!accept_i) begin
                bubble_o <= bubble_o + core_pipe_pkg::cnt_t'(1);
            end
        end
    end

endmodule

/* decoder.sv */
`timescale 1ns/10ps

module decoder (
    input  core_isa_pkg::inst_t    inst_i,
    output core_isa_pkg::rf_addr_t rs1_o,
    output core_isa_pkg::rf_addr_t rs2_o,
    output core_isa_pkg::rf_addr_t rd_o,
    output core_isa_pkg::xlen_t    imm_o,
    output logic                   use_imm_o,
    output core_isa_pkg::alu_op_t  alu_op_o,
    output logic                   rd_we_o
);

    core_isa_pkg::opcode_t opcode;
    core_isa_pkg::funct3_t funct3;
    core_isa_pkg::funct7_t funct7;
    logic                  op_reg;
    logic                  op_imm;
    logic                  shift_imm;
    logic                  alt;

    // field split
    assign opcode = inst_i[6:0];
    assign rd_o   = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    assign op_reg = (opcode == core_isa_pkg::OPC_OP);
    assign op_imm = (opcode == core_isa_pkg::OPC_OP_IMM);
    assign alt    = funct7[core_isa_pkg::F7_ALT_BIT];

    // slli, srli, srai carry a shamt, not a signed immediate
    assign shift_imm = op_imm &&
                       ((funct3 == core_isa_pkg::F3_SLL) || (funct3 == core_isa_pkg::F3_SRL));

    assign imm_o = shift_imm ?
        {{(core_isa_pkg::XLEN-core_isa_pkg::SHAMT_W){1'b0}},
         inst_i[20 +: core_isa_pkg::SHAMT_W]} :
        {{(core_isa_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};

    always_comb begin
        case (funct3)
            // no subi, so alt only counts for register ops
            core_isa_pkg::F3_ADD:  alu_op_o = (op_reg && alt) ? core_isa_pkg::ALU_SUB :
                                                                core_isa_pkg::ALU_ADD;
            core_isa_pkg::F3_SLL:  alu_op_o = core_isa_pkg::ALU_SLL;
            core_isa_pkg::F3_SLT:  alu_op_o = core_isa_pkg::ALU_SLT;
            core_isa_pkg::F3_SLTU: alu_op_o = core_isa_pkg::ALU_SLTU;
            core_isa_pkg::F3_XOR:  alu_op_o = core_isa_pkg::ALU_XOR;
            core_isa_pkg::F3_SRL:  alu_op_o = alt ? core_isa_pkg::ALU_SRA : core_isa_pkg::ALU_SRL;
            core_isa_pkg::F3_OR:   alu_op_o = core_isa_pkg::ALU_OR;
            core_isa_pkg::F3_AND:  alu_op_o = core_isa_pkg::ALU_AND;
            default:               alu_op_o = core_isa_pkg::ALU_ADD;
        endcase
    end

    assign use_imm_o = op_imm;
    // x0 and unknown opcodes never write
    assign rd_we_o   = (op_reg || op_imm) && (rd_o != '0);

endmodule

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                   clk,
    input  logic                   we_i,
    input  core_isa_pkg::rf_addr_t waddr_i,
    input  core_isa_pkg::xlen_t    wdata_i,
    input  core_isa_pkg::rf_addr_t raddr_a_i,
    input  core_isa_pkg::rf_addr_t raddr_b_i,
    output core_isa_pkg::xlen_t    rdata_a_o,
    output core_isa_pkg::xlen_t    rdata_b_o
);

    core_isa_pkg::xlen_t regs [core_isa_pkg::RF_DEPTH];

    // write at the end of the writeback cycle
    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

/* operand_forwarding.sv */
`timescale 1ns/10ps

module operand_forwarding (
    input  core_isa_pkg::rf_addr_t  rs1_dec_i,
    input  core_isa_pkg::rf_addr_t  rs2_dec_i,
    input  core_isa_pkg::rf_addr_t  rs1_exe_i,
    input  core_isa_pkg::rf_addr_t  rs2_exe_i,
    input  logic                    use_imm_exe_i,
    input  core_isa_pkg::rf_addr_t  rd_mem_i,
    input  logic                    rd_we_mem_i,
    input  core_isa_pkg::rf_addr_t  rd_wbk_i,
    input  logic                    rd_we_wbk_i,
    output core_pipe_pkg::fwd_sel_t fwd_rs1_dec_o,
    output core_pipe_pkg::fwd_sel_t fwd_rs2_dec_o,
    output core_pipe_pkg::fwd_sel_t fwd_a_exe_o,
    output core_pipe_pkg::fwd_sel_t fwd_b_exe_o
);

    // newest result wins, x0 always comes from the register file
    function automatic core_pipe_pkg::fwd_sel_t sel_src(
        input core_isa_pkg::rf_addr_t rs,
        input core_isa_pkg::rf_addr_t rd_mem,
        input logic                   we_mem,
        input core_isa_pkg::rf_addr_t rd_wbk,
        input logic                   we_wbk
    );
        core_pipe_pkg::fwd_sel_t sel;
        sel = core_pipe_pkg::FWD_REG;
        if (rs != '0) begin
            if (we_mem && (rd_mem == rs)) begin
                sel = core_pipe_pkg::FWD_MEM;
            end else if (we_wbk && (rd_wbk == rs)) begin
                sel = core_pipe_pkg::FWD_WBK;
            end
        end
        return sel;
    endfunction

    // decode only sees the write that lands at the end of this cycle
    assign fwd_rs1_dec_o = sel_src(rs1_dec_i, rd_mem_i, 1'b0, rd_wbk_i, rd_we_wbk_i);
    assign fwd_rs2_dec_o = sel_src(rs2_dec_i, rd_mem_i, 1'b0, rd_wbk_i, rd_we_wbk_i);

    assign fwd_a_exe_o = sel_src(rs1_exe_i, rd_mem_i, rd_we_mem_i, rd_wbk_i, rd_we_wbk_i);
    assign fwd_b_exe_o = use_imm_exe_i ? core_pipe_pkg::FWD_REG :
                         sel_src(rs2_exe_i, rd_mem_i, rd_we_mem_i, rd_wbk_i, rd_we_wbk_i);

endmodule

/* alu.sv */
`timescale 1ns/10ps

module alu (
    input  core_isa_pkg::alu_op_t op_i,
    input  core_isa_pkg::xlen_t   a_i,
    input  core_isa_pkg::xlen_t   b_i,
    output core_isa_pkg::xlen_t   y_o
);

    logic [core_isa_pkg::SHAMT_W-1:0] shamt;

    assign shamt = b_i[core_isa_pkg::SHAMT_W-1:0];

    always_comb begin
        case (op_i)
            core_isa_pkg::ALU_ADD:  y_o = a_i + b_i;
            core_isa_pkg::ALU_SUB:  y_o = a_i - b_i;
            core_isa_pkg::ALU_SLL:  y_o = a_i << shamt;
            core_isa_pkg::ALU_SRL:  y_o = a_i >> shamt;
            core_isa_pkg::ALU_SRA:  y_o = core_isa_pkg::xlen_t'($signed(a_i) >>> shamt);
            // compares give 0 or 1
            core_isa_pkg::ALU_SLT:  y_o = core_isa_pkg::xlen_t'($signed(a_i) < $signed(b_i));
            core_isa_pkg::ALU_SLTU: y_o = core_isa_pkg::xlen_t'(a_i < b_i);
            core_isa_pkg::ALU_XOR:  y_o = a_i ^ b_i;
            core_isa_pkg::ALU_OR:   y_o = a_i | b_i;
            core_isa_pkg::ALU_AND:  y_o = a_i & b_i;
            default:                y_o = '0;
        endcase
    end

endmodule

/* rv_core.sv */
`timescale 1ns/10ps

module rv_core (
    input  logic                   clk,
    input  logic                   rst,
    input  core_isa_pkg::inst_t    inst_i,
    input  logic                   inst_valid_i,
    output logic                   run_o,
    output logic                   wb_valid_o,
    output logic                   wb_we_o,
    output core_isa_pkg::rf_addr_t wb_addr_o,
    output core_isa_pkg::xlen_t    wb_data_o,
    output core_pipe_pkg::cnt_t    cycle_o,
    output core_pipe_pkg::cnt_t    instret_o,
    output core_pipe_pkg::cnt_t    bubble_o
);

    logic accept;

    // decode stage
    logic                    v_dec;
    core_isa_pkg::inst_t     inst_dec;
    core_isa_pkg::rf_addr_t  rs1_dec, rs2_dec, rd_dec;
    core_isa_pkg::xlen_t     imm_dec, rf_a_dec, rf_b_dec, op_a_dec, op_b_dec;
    logic                    use_imm_dec, rd_we_dec;
    core_isa_pkg::alu_op_t   alu_op_dec;
    core_pipe_pkg::fwd_sel_t fwd_rs1_dec, fwd_rs2_dec;

    // execute stage
    logic                    v_exe, rd_we_exe, use_imm_exe;
    core_isa_pkg::rf_addr_t  rs1_exe, rs2_exe, rd_exe;
    core_isa_pkg::xlen_t     op_a_exe, op_b_exe, a_exe, b_exe, res_exe;
    core_isa_pkg::alu_op_t   alu_op_exe;
    core_pipe_pkg::fwd_sel_t fwd_a_exe, fwd_b_exe;

    // memory and writeback stages
    logic                    v_mem, rd_we_mem, v_wbk, rd_we_wbk;
    core_isa_pkg::rf_addr_t  rd_mem, rd_wbk;
    core_isa_pkg::xlen_t     res_mem, res_wbk;

    function automatic core_isa_pkg::xlen_t fwd_mux(
        input core_pipe_pkg::fwd_sel_t sel,
        input core_isa_pkg::xlen_t     reg_val,
        input core_isa_pkg::xlen_t     mem_val,
        input core_isa_pkg::xlen_t     wbk_val
    );
        core_isa_pkg::xlen_t val;
        case (sel)
            core_pipe_pkg::FWD_MEM: val = mem_val;
            core_pipe_pkg::FWD_WBK: val = wbk_val;
            default:                val = reg_val;
        endcase
        return val;
    endfunction

    pipe_ctrl u_pipe_ctrl (.clk(clk), .rst(rst), .run_o(run_o));

    assign accept = inst_valid_i && run_o;

    perf_counter u_perf_counter (
        .clk       (clk),
        .rst       (rst),
        .run_i     (run_o),
        .accept_i  (accept),
        .retire_i  (wb_valid_o),
        .cycle_o   (cycle_o),
        .instret_o (instret_o),
        .bubble_o  (bubble_o)
    );

    //--------------------------------------------------------------------
    // decode
    always_ff @(posedge clk) begin
        if (rst) begin
            v_dec <= 1'b0;
        end else begin
            v_dec <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_dec <= inst_i;
        end
    end

    decoder u_decoder (
        .inst_i    (inst_dec),
        .rs1_o     (rs1_dec),
        .rs2_o     (rs2_dec),
        .rd_o      (rd_dec),
        .imm_o     (imm_dec),
        .use_imm_o (use_imm_dec),
        .alu_op_o  (alu_op_dec),
        .rd_we_o   (rd_we_dec)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .we_i      (rd_we_wbk),
        .waddr_i   (rd_wbk),
        .wdata_i   (res_wbk),
        .raddr_a_i (rs1_dec),
        .raddr_b_i (rs2_dec),
        .rdata_a_o (rf_a_dec),
        .rdata_b_o (rf_b_dec)
    );

    operand_forwarding u_operand_forwarding (
        .rs1_dec_i     (rs1_dec),
        .rs2_dec_i     (rs2_dec),
        .rs1_exe_i     (rs1_exe),
        .rs2_exe_i     (rs2_exe),
        .use_imm_exe_i (use_imm_exe),
        .rd_mem_i      (rd_mem),
        .rd_we_mem_i   (rd_we_mem),
        .rd_wbk_i      (rd_wbk),
        .rd_we_wbk_i   (rd_we_wbk),
        .fwd_rs1_dec_o (fwd_rs1_dec),
        .fwd_rs2_dec_o (fwd_rs2_dec),
        .fwd_a_exe_o   (fwd_a_exe),
        .fwd_b_exe_o   (fwd_b_exe)
    );

    // decode never sees a memory-stage match
    assign op_a_dec = fwd_mux(fwd_rs1_dec, rf_a_dec, res_mem, res_wbk);
    assign op_b_dec = use_imm_dec ? imm_dec : fwd_mux(fwd_rs2_dec, rf_b_dec, res_mem, res_wbk);

    //--------------------------------------------------------------------
    // execute
    always_ff @(posedge clk) begin
        if (rst) begin
            v_exe     <= 1'b0;
            rd_we_exe <= 1'b0;
        end else begin
            v_exe     <= v_dec;
            rd_we_exe <= v_dec && rd_we_dec;
        end
    end

    always_ff @(posedge clk) begin
        op_a_exe    <= op_a_dec;
        op_b_exe    <= op_b_dec;
        alu_op_exe  <= alu_op_dec;
        use_imm_exe <= use_imm_dec;
        rs1_exe     <= rs1_dec;
        rs2_exe     <= rs2_dec;
        rd_exe      <= rd_dec;
    end

    assign a_exe = fwd_mux(fwd_a_exe, op_a_exe, res_mem, res_wbk);
    assign b_exe = fwd_mux(fwd_b_exe, op_b_exe, res_mem, res_wbk);

    alu u_alu (.op_i(alu_op_exe), .a_i(a_exe), .b_i(b_exe), .y_o(res_exe));

    //--------------------------------------------------------------------
    // memory and writeback, result only
    always_ff @(posedge clk) begin
        if (rst) begin
            v_mem     <= 1'b0;
            rd_we_mem <= 1'b0;
            v_wbk     <= 1'b0;
            rd_we_wbk <= 1'b0;
        end else begin
            v_mem     <= v_exe;
            rd_we_mem <= rd_we_exe;
            v_wbk     <= v_mem;
            rd_we_wbk <= rd_we_mem;
        end
    end

    always_ff @(posedge clk) begin
        res_mem <= res_exe;
        rd_mem  <= rd_exe;
        res_wbk <= res_mem;
        rd_wbk  <= rd_mem;
    end

    assign wb_valid_o = v_wbk;
    assign wb_we_o    = rd_we_wbk;
    assign wb_addr_o  = rd_wbk;
    assign wb_data_o  = res_wbk;

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o
);

    // 4 ns period
    localparam real HALF_PERIOD = 2.0;

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

/* rv_core_assert.sv */
`timescale 1ns/10ps

module rv_core_assert (
    input logic                clk,
    input logic                rst,
    input logic                accept,
    input logic                run_o,
    input logic                wb_valid_o,
    input logic                wb_we_o,
    input core_pipe_pkg::cnt_t cycle_o,
    input core_pipe_pkg::cnt_t instret_o,
    input core_pipe_pkg::cnt_t bubble_o
);

    // number of failed assertions
    int fail_cnt = 0;

    // flush lasts one cycle per stage, then run for good
    a_flush_len: assert property (@(posedge clk)
        $fell(rst) |-> !run_o [*4] ##1 run_o)
        else begin
            fail_cnt++;
            $error("run_o did not rise after the flush sequence");
        end

    a_run_holds: assert property (@(posedge clk) disable iff (rst)
        run_o |=> run_o)
        else begin
            fail_cnt++;
            $error("run_o fell after the core started running");
        end

    // quiet outputs before run
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        !run_o |-> (!wb_valid_o && !wb_we_o && cycle_o == '0 &&
                    instret_o == '0 && bubble_o == '0))
        else begin
            fail_cnt++;
            $error("core active or counting during the flush");
        end

    // writeback starts three edges after acceptance, so the fourth edge samples it
    a_retire_latency: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##4 wb_valid_o)
        else begin
            fail_cnt++;
            $error("accepted instruction did not reach writeback three edges later");
        end

    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o |-> $past(accept, 4))
        else begin
            fail_cnt++;
            $error("retirement without a matching acceptance");
        end

    a_cycle_step: assert property (@(posedge clk) disable iff (rst)
        run_o |=> cycle_o == $past(cycle_o) + 1)
        else begin
            fail_cnt++;
            $error("cycle counter did not advance");
        end

    a_bubble_step: assert property (@(posedge clk) disable iff (rst)
        (run_o && !accept) |=> bubble_o == $past(bubble_o) + 1)
        else begin
            fail_cnt++;
            $error("bubble counter missed an idle run cycle");
        end

endmodule

bind rv_core rv_core_assert u_rv_core_assert (
    .clk        (clk),
    .rst        (rst),
    .accept     (accept),
    .run_o      (run_o),
    .wb_valid_o (wb_valid_o),
    .wb_we_o    (wb_we_o),
    .cycle_o    (cycle_o),
    .instret_o  (instret_o),
    .bubble_o   (bubble_o)
);

/* tb_top.sv */
`timescale 1ns/10ps

module tb_top;

    localparam int N_INIT  = 7;
    localparam int N_CHAIN = 19 * 3;
    localparam int N_X0    = 4;
    localparam int N_RAND  = 200;
    localparam int N_PLAN  = N_INIT + N_CHAIN + N_X0 + N_RAND + 8;
    localparam int LIMIT   = 10 * N_PLAN + 100;

    logic                   clk;
    logic                   rst;
    core_isa_pkg::inst_t    inst_i;
    logic                   inst_valid_i;
    logic                   run_o;
    logic                   wb_valid_o;
    logic                   wb_we_o;
    core_isa_pkg::rf_addr_t wb_addr_o;
    core_isa_pkg::xlen_t    wb_data_o;
    core_pipe_pkg::cnt_t    cycle_o;
    core_pipe_pkg::cnt_t    instret_o;
    core_pipe_pkg::cnt_t    bubble_o;

    integer              seed;
    int                  val_errors;
    int                  cnt_errors;
    int                  assert_errors;
    int                  cyc;
    int                  n_accept;
    int                  bubble_exp;
    logic [31:0]         model [32];
    core_isa_pkg::inst_t in_flight [$];

    tb_clk_gen u_clk_gen (.clk_o(clk));

    rv_core i_dut (
        .clk          (clk),
        .rst          (rst),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .run_o        (run_o),
        .wb_valid_o   (wb_valid_o),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .cycle_o      (cycle_o),
        .instret_o    (instret_o),
        .bubble_o     (bubble_o)
    );

    // ----------------------------------------------------------------------
    // instruction encoding and reference model
    function automatic logic [31:0] op_word(input int idx, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [11:0] imm);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] iv;
        f7 = 7'h00;
        iv = imm;
        case (idx)
            0: f3 = 3'd0;
            1: begin
                f3 = 3'd0;
                f7 = 7'h20;
            end
            2: f3 = 3'd1;
            3: f3 = 3'd2;
            4: f3 = 3'd3;
            5: f3 = 3'd4;
            6: f3 = 3'd5;
            7: begin
                f3 = 3'd5;
                f7 = 7'h20;
            end
            8: f3 = 3'd6;
            9: f3 = 3'd7;
            10: f3 = 3'd0;
            11: f3 = 3'd2;
            12: f3 = 3'd3;
            13: f3 = 3'd4;
            14: f3 = 3'd6;
            15: f3 = 3'd7;
            16: begin
                f3 = 3'd1;
                iv = {7'h00, imm[4:0]};
            end
            17: begin
                f3 = 3'd5;
                iv = {7'h00, imm[4:0]};
            end
            default: begin
                f3 = 3'd5;
                iv = {7'h20, imm[4:0]};
            end
        endcase
        if (idx < 10) begin
            return {f7, rs2, rs1, f3, rd, 7'b0110011};
        end
        return {iv, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] ref_exec(input logic [31:0] w, input logic [31:0] a,
                                             input logic [31:0] rb);
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] y;
        b  = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : rb;
        sh = b[4:0];
        case (w[14:12])
            3'd0: y = (w[6:0] == 7'b0110011 && w[30]) ? a - b : a + b;
            3'd1: y = a << sh;
            3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: y = (a < b) ? 32'd1 : 32'd0;
            3'd4: y = a ^ b;
            3'd5: y = w[30] ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6: y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // ----------------------------------------------------------------------
    // drive helpers, inputs change 0.5 ns after the edge
    task automatic send(input logic [31:0] w);
        @(posedge clk);
        #0.5;
        inst_i       = w;
        inst_valid_i = 1'b1;
    endtask

    task automatic idle();
        @(posedge clk);
        #0.5;
        inst_valid_i = 1'b0;
        inst_i       = 32'($random(seed));
    endtask

    task automatic send_random();
        logic [31:0] r;
        logic [31:0] f;
        r = $random(seed);
        f = $random(seed);
        if (r[27:26] == 2'b00) begin
            idle();
        end
        if (r[31:28] == 4'h0) begin
            // unsupported opcode
            send({f[31:7], 7'b0000011});
        end else begin
            send(op_word((r & 32'h7fff_ffff) % 19, {2'b00, f[2:0]}, {2'b00, f[5:3]},
                         {2'b00, f[8:6]}, f[20:9]));
        end
    endtask

    // ----------------------------------------------------------------------
    // acceptance tracking and retirement checks
    always @(posedge clk) begin
        logic [31:0] w;
        logic [31:0] exp_data;
        logic        exp_we;
        if (!rst && wb_valid_o) begin
            if (in_flight.size() == 0) begin
                $display("retirement seen with no accepted instruction in flight at %0t",
                         $time);
                val_errors++;
            end else begin
                w        = in_flight.pop_front();
                exp_we   = (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011) && w[11:7] != 0;
                exp_data = ref_exec(w, model[w[19:15]], model[w[24:20]]);
                assert (wb_addr_o == w[11:7]) else begin
                    $display("Error at %0t: wb_addr_o expected %0d actual %0d",
                             $time, w[11:7], wb_addr_o);
                    val_errors++;
                end
                assert (wb_we_o == exp_we) else begin
                    $display("Error at %0t: wb_we_o expected %b actual %b",
                             $time, exp_we, wb_we_o);
                    val_errors++;
                end
                if (exp_we) begin
                    assert (wb_data_o == exp_data) else begin
                        $display("Error at %0t: wb_data_o expected %h actual %h",
                                 $time, exp_data, wb_data_o);
                        val_errors++;
                    end
                    model[w[11:7]] = exp_data;
                end
            end
        end
        if (!rst && run_o && inst_valid_i) begin
            in_flight.push_back(inst_i);
            n_accept++;
        end
        if (!rst && run_o && !inst_valid_i) begin
            bubble_exp++;
        end
    end

    // run limit
    always @(posedge clk) begin
        cyc++;
        if (cyc >= LIMIT) begin
            $display("timeout after %0d cycles, pipeline did not drain", cyc);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    initial begin
        seed          = 32'hd439_8537;
        val_errors    = 0;
        cnt_errors    = 0;
        assert_errors = 0;
        cyc           = 0;
        n_accept      = 0;
        bubble_exp    = 0;
        rst           = 1'b1;
        inst_i        = '0;
        inst_valid_i  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        #0.5;
        rst = 1'b0;
        // offered during the flush, must never retire
        while (!run_o) begin
            send_random();
        end

        for (int r = 1; r <= N_INIT; r++) begin
            send(op_word(10, 5'(r), 5'd0, 5'd0, 12'($random(seed))));
        end

        // dependent chains through mem, wbk and decode bypass
        for (int k = 0; k < 19; k++) begin
            send(op_word(k, 5'd1, 5'd1, 5'd1, 12'($random(seed))));
            send(op_word(k, 5'd2, 5'd1, 5'd2, 12'($random(seed))));
            idle();
            send(op_word(k, 5'd3, 5'd1, 5'd2, 12'($random(seed))));
        end

        // x0 writes and an unsupported opcode
        send(op_word(10, 5'd0, 5'd1, 5'd0, 12'h7ff));
        send({25'h0abcd5, 7'b0000011});
        send(op_word(0, 5'd4, 5'd0, 5'd0, 12'h0));
        send(op_word(10, 5'd5, 5'd0, 5'd0, 12'h0));

        for (int i = 0; i < N_RAND; i++) begin
            send_random();
        end
        repeat (3) idle();

        while (in_flight.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #0.5;

        // every instruction sent once running must have been accepted
        assert (n_accept >= N_INIT + N_CHAIN + N_X0 + N_RAND) else begin
            $display("only %0d instructions were accepted, some sent after the flush were lost",
                     n_accept);
            cnt_errors++;
        end
        assert (instret_o == 32'(n_accept)) else begin
            $display("Error at %0t: instret_o expected %0d actual %0d",
                     $time, n_accept, instret_o);
            cnt_errors++;
        end
        assert (cycle_o == 32'(n_accept + bubble_exp)) else begin
            $display("Error at %0t: cycle_o expected %0d actual %0d",
                     $time, n_accept + bubble_exp, cycle_o);
            cnt_errors++;
        end
        assert (bubble_o == 32'(bubble_exp)) else begin
            $display("Error at %0t: bubble_o expected %0d actual %0d",
                     $time, bubble_exp, bubble_o);
            cnt_errors++;
        end

        assert_errors = i_dut.u_rv_core_assert.fail_cnt;
        $display("value errors %0d, counter errors %0d, assertion errors %0d, accepted %0d",
                 val_errors, cnt_errors, assert_errors, n_accept);
        if (val_errors == 0 && cnt_errors == 0 && assert_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
core_isa_pkg.sv
core_pipe_pkg.sv
pipe_ctrl.sv
perf_counter.sv
decoder.sv
reg_file.sv
operand_forwarding.sv
alu.sv
rv_core.sv
tb_clk_gen.sv
rv_core_assert.sv
tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_top -o sim_tb_top
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
